// File: sim.f
verilog/cpu_pkg.sv
verilog/axi_pkg.sv
verilog/fetch_unit.sv
verilog/inst_rom.sv
verilog/fetch_top.sv
test/fetch_chk.sv
test/fetch_checker.sv
test/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator, from the project root
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module fetch_tb -o sim_fetch \
    && ./obj_dir/sim_fetch > sim.log 2>&1 \
    || echo "Errors found" >> sim.log

cat sim.log

grep -q "Errors found" sim.log && exit 1 || exit 0

// File: inst_rom.hex
00000013
00a00093
00100113
002081b3
40310233
0041f2b3
0052e333
00634393
00239413
0013d493
fff00513
00a505b3
00b02623
00c02683
00d58733
00e707b3
01078813
00f80893
01189913
0028d993
01390a33
014a0ab3
015a8b33
016b0bb3
01c0006f
fe0b8ee3
00008c67
00c00ceb
01ad0d33
01bd8db3
01ce0e33
00100073

// File: test/fetch_cases.txt
# name fetches stall_bound redir_slot redir_target(hex) stop_slot stop_delay
# Slots count fetches within the test, -1 means none; stop_delay is cycles into the valid window
reset_first 1 0 -1 00000000 -1 0
seq_wrap 36 0 -1 00000000 -1 0
redirect 6 0 2 30000010 -1 0
redirect_far 4 1 0 30000078 -1 0
stop_repeat 5 0 -1 00000000 1 0
stop_late 4 3 -1 00000000 2 2
both_same 4 0 1 30000020 1 0
redir_first 4 2 1 30000030 1 1
stall_rand 24 6 -1 00000000 -1 0
stall_mix 16 5 3 3000005c 9 0
redir_wrap 6 2 0 30000074 -1 0
seq_tail 8 1 -1 00000000 -1 0

// File: test/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    logic            clock;
    logic            reset;
    cpu_pkg::pc_t    dnpc;
    logic            dnpc_flag;
    logic            pipe_stop;
    logic            ready;
    cpu_pkg::pc_t    pc;
    cpu_pkg::inst_t  inst;
    logic            valid;

    logic [127:0]    test_name;
    logic            test_done;
    int              test_fetches;
    int              error_count;
    int              tests_run;

    logic [31:0]     lfsr_state;
    int              cycles;
    int              cycle_limit;

    fetch_top u_dut (
        .clock     (clock),
        .reset     (reset),
        .dnpc      (dnpc),
        .dnpc_flag (dnpc_flag),
        .pipe_stop (pipe_stop),
        .ready     (ready),
        .pc        (pc),
        .inst      (inst),
        .valid     (valid)
    );

    fetch_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .pc           (pc),
        .inst         (inst),
        .valid        (valid),
        .ready        (ready),
        .dnpc         (dnpc),
        .dnpc_flag    (dnpc_flag),
        .pipe_stop    (pipe_stop),
        .test_name    (test_name),
        .test_done    (test_done),
        .test_fetches (test_fetches),
        .error_count  (error_count),
        .tests_run    (tests_run)
    );

    bind fetch_unit fetch_chk u_handshake_chk (
        .clock   (clock),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .valid   (valid),
        .ready   (ready),
        .pc      (pc),
        .inst    (inst)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // --------------------
    // Random stalls
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_stall(input int bound, output int stall);
        int bits;
        bits = 0;
        for (int b = 0; b < 4; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = (bits << 1) | int'(lfsr_state[0]);
        end
        stall = (bound > 0) ? (bits % (bound + 1)) : 0;
    endtask

    // Hang guard
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // One fetch with stall and optional pulses on the valid window
    task automatic run_fetch(input int stall, input logic do_redir, input cpu_pkg::pc_t target,
                             input logic do_stop, input int stop_delay);
        int c;
        int hold;
        logic done;
        c    = 0;
        done = 1'b0;
        hold = stall;
        if (do_stop && stop_delay > hold) begin
            hold = stop_delay;
        end
        while (!valid) begin
            @(negedge clock);
        end
        while (!done) begin
            dnpc      = target;
            dnpc_flag = do_redir && (c == 0);
            pipe_stop = do_stop && (c == stop_delay);
            ready     = (c >= hold);
            @(negedge clock);
            done = ready;
            c    = c + 1;
        end
        dnpc_flag = 1'b0;
        pipe_stop = 1'b0;
        ready     = 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main
        int            fd;
        int            n;
        int            stall;
        string         line;
        logic [127:0]  name;
        int            fetches;
        int            bound;
        int            rslot;
        logic [31:0]   target;
        int            sslot;
        int            sdelay;
        logic [127:0]  q_name [$];
        int            q_fetch [$];
        int            q_bound [$];
        int            q_rslot [$];
        logic [31:0]   q_target [$];
        int            q_sslot [$];
        int            q_sdelay [$];
        reset        = 1'b1;
        dnpc         = '0;
        dnpc_flag    = 1'b0;
        pipe_stop    = 1'b0;
        ready        = 1'b0;
        test_name    = '0;
        test_done    = 1'b0;
        test_fetches = 0;
        lfsr_state   = 32'h1127_95a0;
        cycle_limit  = 0;

        fd = $fopen("test/fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file test/fetch_cases.txt");
            $display("Errors found");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    name = '0;
                    n = $sscanf(line, "%s %d %d %d %h %d %d", name, fetches, bound,
                                rslot, target, sslot, sdelay);
                    if (n == 7) begin
                        q_name.push_back(name);
                        q_fetch.push_back(fetches);
                        q_bound.push_back(bound);
                        q_rslot.push_back(rslot);
                        q_target.push_back(target);
                        q_sslot.push_back(sslot);
                        q_sdelay.push_back(sdelay);
                        cycle_limit = cycle_limit + fetches * (bound + 8);
                    end
                end
            end
            $fclose(fd);
            // Reset and end-of-test slack
            cycle_limit = cycle_limit + 20 + 4 * q_name.size();

            repeat (2) @(negedge clock);
            reset = 1'b0;

            for (int t = 0; t < q_name.size(); t++) begin
                test_name = q_name[t];
                for (int i = 0; i < q_fetch[t]; i++) begin
                    draw_stall(q_bound[t], stall);
                    run_fetch(stall, q_rslot[t] == i, q_target[t],
                              q_sslot[t] == i, q_sdelay[t]);
                end
                test_fetches = q_fetch[t];
                test_done    = 1'b1;
                @(negedge clock);
                test_done    = 1'b0;
            end

            @(negedge clock);
            $display("Tests run: %0d, errors: %0d", tests_run, error_count);
            if (error_count == 0 && tests_run == q_name.size() && tests_run > 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// File: test/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input  logic            clock,
    input  logic            reset,
    input  cpu_pkg::pc_t    pc,
    input  cpu_pkg::inst_t  inst,
    input  logic            valid,
    input  logic            ready,
    input  cpu_pkg::pc_t    dnpc,
    input  logic            dnpc_flag,
    input  logic            pipe_stop,
    input  logic [127:0]    test_name,
    input  logic            test_done,
    input  int              test_fetches,
    output int              error_count,
    output int              tests_run
);

    cpu_pkg::inst_t  rom [cpu_pkg::rom_words];

    // Reference PC and the first flag seen in the current window
    cpu_pkg::pc_t    exp_pc;
    logic            stop_seen;
    logic            redir_seen;
    cpu_pkg::pc_t    target_seen;
    int              handoffs;
    int              test_errors;

    initial begin
        $readmemh("inst_rom.hex", rom);
        error_count = 0;
        tests_run   = 0;
    end

    always @(posedge clock) begin : model
        logic            stop_now;
        logic            redir_now;
        cpu_pkg::pc_t    tgt;
        cpu_pkg::inst_t  exp_inst;
        if (reset) begin
            exp_pc      = cpu_pkg::reset_pc;
            stop_seen   = 1'b0;
            redir_seen  = 1'b0;
            target_seen = '0;
            handoffs    = 0;
            test_errors = 0;
        end else begin
            stop_now  = stop_seen;
            redir_now = redir_seen;
            tgt       = target_seen;
            if (valid) begin
                // First flag wins; stop beats redirect on the same clock
                if (!stop_now && !redir_now) begin
                    if (pipe_stop) begin
                        stop_now = 1'b1;
                    end else if (dnpc_flag) begin
                        redir_now = 1'b1;
                        tgt       = dnpc;
                    end
                end
                if (ready) begin
                    exp_inst = rom[exp_pc[6:2]];
                    if (pc !== exp_pc) begin
                        $display("Mismatch %0s pc: expected %h actual %h",
                                 test_name, exp_pc, pc);
                        test_errors = test_errors + 1;
                    end
                    if (inst !== exp_inst) begin
                        $display("Mismatch %0s inst: expected %h actual %h",
                                 test_name, exp_inst, inst);
                        test_errors = test_errors + 1;
                    end
                    handoffs = handoffs + 1;
                    if (redir_now && !stop_now) begin
                        exp_pc = tgt;
                    end else if (!stop_now) begin
                        exp_pc = exp_pc + 32'd4;
                    end
                    stop_now  = 1'b0;
                    redir_now = 1'b0;
                end
            end
            stop_seen   = stop_now;
            redir_seen  = redir_now;
            target_seen = tgt;

            // --------------------
            // End of one test
            // --------------------
            if (test_done) begin
                if (handoffs != test_fetches) begin
                    $display("Test %0s handed off %0d instructions instead of %0d",
                             test_name, handoffs, test_fetches);
                    test_errors = test_errors + 1;
                end
                if (test_errors == 0) begin
                    $display("Test %0s: pass, %0d fetches", test_name, handoffs);
                end else begin
                    $display("Test %0s: FAIL, %0d errors", test_name, test_errors);
                end
                error_count = error_count + test_errors;
                tests_run   = tests_run + 1;
                handoffs    = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// File: test/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
    input logic               clock,
    input logic               reset,
    input axi_pkg::ar_chan_t  ar,
    input logic               arvalid,
    input logic               arready,
    input logic               rvalid,
    input logic               valid,
    input logic               ready,
    input cpu_pkg::pc_t       pc,
    input cpu_pkg::inst_t     inst
);

    // Set by an AR handshake, cleared by the data beat
    logic pending;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (arvalid && arready) begin
            pending <= 1'b1;
        end else if (rvalid) begin
            pending <= 1'b0;
        end
    end

    // No new request while a read is outstanding, and its address stays put
    ar_stable: assert property (@(posedge clock) disable iff (reset)
        pending |-> !arvalid && $stable(ar))
        else $error("New AR request or address change while a read was outstanding");

    hold_stable: assert property (@(posedge clock) disable iff (reset)
        valid && !ready |=> valid && $stable(inst) && $stable(pc))
        else $error("Instruction or pc changed while decode was stalling");

    r_after_ar: assert property (@(posedge clock) disable iff (reset)
        rvalid |-> pending)
        else $error("Read data returned without an outstanding AR handshake");

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic            clock,
    input  logic            reset,
    input  cpu_pkg::pc_t    dnpc,
    input  logic            dnpc_flag,
    input  logic            pipe_stop,
    input  logic            ready,
    output cpu_pkg::pc_t    pc,
    output cpu_pkg::inst_t  inst,
    output logic            valid
);

    // AXI read channels between fetch and ROM
    axi_pkg::ar_chan_t  ar;
    logic               arvalid;
    logic               arready;
    axi_pkg::r_chan_t   r;
    logic               rvalid;
    logic               rready;

    fetch_unit u_fetch (
        .clock     (clock),
        .reset     (reset),
        .dnpc      (dnpc),
        .dnpc_flag (dnpc_flag),
        .pipe_stop (pipe_stop),
        .pc        (pc),
        .inst      (inst),
        .valid     (valid),
        .ready     (ready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    inst_rom u_rom (
        .clock   (clock),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

// File: verilog/inst_rom.sv
`timescale 1ns/1ps

module inst_rom (
    input  logic               clock,
    input  logic               reset,
    input  axi_pkg::ar_chan_t  ar,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::r_chan_t   r,
    output logic               rvalid,
    input  logic               rready
);

    localparam int cnt_w = $clog2(axi_pkg::rom_latency + 1);

    cpu_pkg::inst_t       mem [cpu_pkg::rom_words];
    cpu_pkg::rom_index_t  rd_index;

    // Zero when idle; counts down to 1, where the beat is presented
    logic [cnt_w-1:0]     count;

    initial begin
        $readmemh("inst_rom.hex", mem);
    end

    // --------------------
    // Handshakes
    // --------------------

    assign arready = (count == '0);
    assign rvalid  = (count == cnt_w'(1));

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (arvalid && arready) begin
            count <= cnt_w'(axi_pkg::rom_latency);
        end else if (count != '0 && (count != cnt_w'(1) || rready)) begin
            count <= count - 1'b1;
        end
    end

    // Word index wraps on address bits 6..2
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rd_index <= ar.addr[2 +: $bits(cpu_pkg::rom_index_t)];
        end
    end

    // --------------------
    // Read data
    // --------------------

    assign r = '{
        data: mem[rd_index],
        resp: axi_pkg::resp_okay,
        last: 1'b1
    };

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clock,
    input  logic               reset,
    input  cpu_pkg::pc_t       dnpc,
    input  logic               dnpc_flag,
    input  logic               pipe_stop,
    output cpu_pkg::pc_t       pc,
    output cpu_pkg::inst_t     inst,
    output logic               valid,
    input  logic               ready,
    output axi_pkg::ar_chan_t  ar,
    output logic               arvalid,
    input  logic               arready,
    input  axi_pkg::r_chan_t   r,
    input  logic               rvalid,
    output logic               rready
);

    typedef enum logic [1:0] {
        issue,
        wait_data,
        hold
    } fetch_state_t;

    fetch_state_t  state;

    // Captured redirect and stop
    logic          stop_held;
    logic          redir_held;
    cpu_pkg::pc_t  target_held;

    logic          capture_en;
    logic          handoff;
    logic          any_held;
    logic          take_stop;
    cpu_pkg::pc_t  next_pc;

    // --------------------
    // Bus side
    // --------------------

    assign ar      = '{addr: pc, size: axi_pkg::size_word, burst: axi_pkg::burst_fixed};
    assign arvalid = (state == issue);
    assign rready  = 1'b1;
    assign valid   = (state == hold);

    // Request, data return, handoff
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= issue;
        end else begin
            case (state)
                issue:     if (arready) state <= wait_data;
                wait_data: if (rvalid)  state <= hold;
                hold:      if (ready)   state <= issue;
                default:   state <= issue;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == wait_data && rvalid) begin
            inst <= r.data;
        end
    end

    // --------------------
    // Redirect and stop
    // --------------------

    // Window runs from the data beat through the handoff clock
    assign capture_en = (state == hold) || (state == wait_data && rvalid);
    assign handoff    = (state == hold) && ready;
    assign any_held   = stop_held || redir_held;

    always_ff @(posedge clock) begin
        if (reset) begin
            stop_held  <= 1'b0;
            redir_held <= 1'b0;
        end else if (handoff) begin
            stop_held  <= 1'b0;
            redir_held <= 1'b0;
        end else if (capture_en && !any_held) begin
            stop_held  <= pipe_stop;
            redir_held <= dnpc_flag && !pipe_stop;
        end
    end

    always_ff @(posedge clock) begin
        if (capture_en && !any_held && dnpc_flag) begin
            target_held <= dnpc;
        end
    end

    // Stop, then redirect, then sequential; a held flag beats a fresh one
    assign take_stop = stop_held || (!any_held && pipe_stop);

    always_comb begin
        if (take_stop) begin
            next_pc = pc;
        end else if (redir_held) begin
            next_pc = target_held;
        end else if (dnpc_flag) begin
            next_pc = dnpc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= cpu_pkg::reset_pc;
        end else if (handoff) begin
            pc <= next_pc;
        end
    end

endmodule

// File: verilog/axi_pkg.sv
package axi_pkg;

    // --------------------
    // Field widths
    // --------------------

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;

    // Read-address payload, single beat only
    typedef struct packed {
        addr_t  addr;
        size_t  size;
        burst_t burst;
    } ar_chan_t;

    // Read-data payload
    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } r_chan_t;

    // --------------------
    // Codes and timing
    // --------------------

    localparam size_t  size_word   = 3'b010;  // 4 bytes per beat
    localparam burst_t burst_fixed = 2'b00;
    localparam resp_t  resp_okay   = 2'b00;

    // Cycles from AR handshake to rvalid
    localparam int rom_latency = 2;

endpackage

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // --------------------
    // Core-side widths
    // --------------------

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // One instruction word
    typedef logic [31:0] inst_t;

    // First fetch address after reset
    localparam pc_t reset_pc = 32'h3000_0000;

    // --------------------
    // Instruction ROM geometry
    // --------------------

    localparam int rom_words = 32;

    // Word index, taken from address bits 6..2
    typedef logic [$clog2(rom_words)-1:0] rom_index_t;

endpackage
